/* filelist.f */
+incdir+hw
hw/sdu_uart_pkg.sv
hw/sdu_cmd_pkg.sv
hw/uart_rx.sv
hw/uart_tx.sv
hw/debug_mem.sv
hw/debug_cmd_proc.sv
hw/sdu_top.sv
tb/sdu_checker.sv
tb/sdu_tb.sv

/* run_sim.sh */
#!/bin/sh
# build and run the serial debug unit testbench with Verilator

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG=sim.log

verilator --binary --timing --assert -j 0 -f filelist.f \
    --top-module sdu_tb --Mdir "$BUILD_DIR" -o sdu_sim
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

"./$BUILD_DIR/sdu_sim" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "TEST FAILED" "$LOG"; then
    exit 1
fi
if ! grep -q "TEST PASSED" "$LOG"; then
    echo "simulation ended without a result"
    exit 1
fi
exit 0

/* tb/sdu_tb.sv */
`include "sdu_settings.svh"

module sdu_tb;
    import sdu_cmd_pkg::*;

    localparam int N_TESTS    = 11;
    localparam int N_PAIRS    = 16;
    localparam int LIMIT      = (N_TESTS + N_PAIRS) * 6 * 10 * `SDU_CLKS_PER_BIT * 2;
    localparam int FIRST_WAIT = 6 * 10 * `SDU_CLKS_PER_BIT;
    localparam int NEXT_WAIT  = 2 * 10 * `SDU_CLKS_PER_BIT;
    localparam int BUSY_WAIT  = 2 * `SDU_CLKS_PER_BIT;

    typedef struct packed {
        logic [7:0] op;
        logic [7:0] addr;
        logic [7:0] dhi;
        logic [7:0] dlo;
        int         n_reply;
        logic [7:0] rep0;
        logic [7:0] rep1;
    } test_vec_s;

    logic       clk;
    logic       arst_n;
    logic       rxd;
    logic       txd;
    logic [7:0] last_rx;
    logic       busy;

    test_vec_s              tests [$];
    string                  names [$];
    logic [`SDU_MEM_DW-1:0] shadow [1 << `SDU_MEM_AW];
    logic [7:0]             written [$];
    logic [7:0]             exp_last = 8'h00;
    int                     n_checks = 0;
    int                     n_mismatch = 0;
    int                     n_other = 0;
    int                     cycles = 0;
    int                     seed = 32'h58e;

    sdu_top dut (
        .clk     (clk),
        .arst_n  (arst_n),
        .rxd     (rxd),
        .txd     (txd),
        .last_rx (last_rx),
        .busy    (busy)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    task automatic add_test(input string name, input logic [7:0] op, input logic [7:0] addr,
                            input logic [7:0] dhi, input logic [7:0] dlo, input int n_reply,
                            input logic [7:0] rep0, input logic [7:0] rep1);
        test_vec_s t;
        t.op      = op;
        t.addr    = addr;
        t.dhi     = dhi;
        t.dlo     = dlo;
        t.n_reply = n_reply;
        t.rep0    = rep0;
        t.rep1    = rep1;
        tests.push_back(t);
        names.push_back(name);
    endtask

    task automatic compare_byte(input string name, input logic [7:0] expected,
                                input logic [7:0] actual);
        n_checks++;
        if (actual !== expected) begin
            n_mismatch++;
            $display("Mismatch %s: expected %02h, actual %02h", name, expected, actual);
        end
    endtask

    task automatic compare_word(input string name, input logic [`SDU_MEM_DW-1:0] expected,
                                input logic [`SDU_MEM_DW-1:0] actual);
        n_checks++;
        if (actual !== expected) begin
            n_mismatch++;
            $display("Mismatch %s: expected %04h, actual %04h", name, expected, actual);
        end
    endtask

    // one serial bit, entered and left on a falling edge
    task automatic drive_bit(input logic v);
        rxd = v;
        repeat (`SDU_CLKS_PER_BIT) @(negedge clk);
    endtask

    task automatic send_byte(input logic [7:0] b);
        logic [7:0] bits;
        int         i;
        bits = b;
        drive_bit(1'b0);
        for (i = 0; i < 8; i++) begin
            drive_bit(bits[0]);
            bits = bits >> 1;
        end
        drive_bit(1'b1);
        if (b != 8'h00) begin
            exp_last = b;
        end
    endtask

    task automatic send_frame(input logic [7:0] op, input logic [7:0] addr,
                              input logic [7:0] dhi, input logic [7:0] dlo);
        @(negedge clk);
        send_byte(op);
        send_byte(addr);
        send_byte(dhi);
        send_byte(dlo);
    endtask

    // samples txd near the middle of each bit
    task automatic receive_byte(input int limit, output logic [7:0] b, output bit ok);
        int waited;
        int i;
        waited = 0;
        b = '0;
        ok = 1'b0;
        @(negedge clk);
        while (txd !== 1'b0 && waited < limit) begin
            @(negedge clk);
            waited++;
        end
        if (txd === 1'b0) begin
            repeat (`SDU_CLKS_PER_BIT / 2) @(negedge clk);
            if (txd === 1'b0) begin
                for (i = 0; i < 8; i++) begin
                    repeat (`SDU_CLKS_PER_BIT) @(negedge clk);
                    b = {txd, b[7:1]};
                end
                repeat (`SDU_CLKS_PER_BIT) @(negedge clk);
                ok = (txd === 1'b1);
            end
        end
    endtask

    task automatic run_frame(input string name, input logic [7:0] op, input logic [7:0] addr,
                             input logic [7:0] dhi, input logic [7:0] dlo, input int n_exp,
                             output logic [7:0] got0, output logic [7:0] got1,
                             output int n_got);
        logic [7:0] b;
        bit         ok;
        bit         extra;
        int         k;
        int         waited;
        got0 = '0;
        got1 = '0;
        n_got = 0;
        ok = 1'b1;
        // reply may start before the last stop bit has ended
        fork
            send_frame(op, addr, dhi, dlo);
            begin
                for (k = 0; k < n_exp && ok; k++) begin
                    receive_byte(k == 0 ? FIRST_WAIT : NEXT_WAIT, b, ok);
                    if (ok) begin
                        if (k == 0) begin
                            got0 = b;
                        end else begin
                            got1 = b;
                        end
                        n_got++;
                    end
                end
            end
        join
        if (n_got < n_exp) begin
            n_other++;
            $display("%s: reply byte %0d never arrived", name, n_got);
        end
        // busy falling marks the end of the reply
        waited = 0;
        extra = 1'b0;
        @(negedge clk);
        while (busy && waited < BUSY_WAIT) begin
            if (txd === 1'b0 && n_got == n_exp) begin
                extra = 1'b1;
            end
            @(negedge clk);
            waited++;
        end
        if (busy) begin
            n_other++;
            $display("%s: busy still high after the reply", name);
        end
        if (extra) begin
            n_other++;
            $display("%s: more reply bytes than expected", name);
        end
        compare_byte({name, " last_rx"}, exp_last, last_rx);
    endtask

    task automatic load_table();
        add_test("wr_a5",       OP_WRITE, 8'hA5, 8'h12, 8'h34, 1, `SDU_ACK_BYTE, 8'h00);
        add_test("rd_a5",       OP_READ,  8'hA5, 8'h00, 8'h00, 2, 8'h12, 8'h34);
        add_test("wr_a5_new",   OP_WRITE, 8'hA5, 8'hBE, 8'hEF, 1, `SDU_ACK_BYTE, 8'h00);
        add_test("rd_a5_new",   OP_READ,  8'hA5, 8'h00, 8'h00, 2, 8'hBE, 8'hEF);
        add_test("wr_03",       OP_WRITE, 8'h03, 8'h00, 8'h11, 1, `SDU_ACK_BYTE, 8'h00);
        add_test("bad_op",      8'h58,    8'h03, 8'hFF, 8'hFF, 1, `SDU_ERR_BYTE, 8'h00);
        add_test("rd_03",       OP_READ,  8'h03, 8'h00, 8'h00, 2, 8'h00, 8'h11);
        // zero opcode and zero last byte, last_rx keeps 55
        add_test("bad_op_zero", 8'h00,    8'h03, 8'h55, 8'h00, 1, `SDU_ERR_BYTE, 8'h00);
        add_test("rd_03_again", OP_READ,  8'h03, 8'h00, 8'h00, 2, 8'h00, 8'h11);
        add_test("wr_ff_zero",  OP_WRITE, 8'hFF, 8'h00, 8'h00, 1, `SDU_ACK_BYTE, 8'h00);
        add_test("rd_ff",       OP_READ,  8'hFF, 8'h00, 8'h00, 2, 8'h00, 8'h00);
    endtask

    // run limit
    initial begin
        while (cycles < LIMIT) begin
            @(posedge clk);
            cycles++;
        end
        $display("timeout: the run did not finish within %0d cycles", LIMIT);
        $display("TEST FAILED");
        $finish;
    end

    initial begin
        logic [7:0]             g0;
        logic [7:0]             g1;
        logic [7:0]             addr;
        logic [`SDU_MEM_DW-1:0] data;
        int                     n_got;
        int                     i;
        int                     p;
        int                     idx;
        arst_n = 1'b0;
        rxd = 1'b1;
        load_table();
        repeat (5) @(posedge clk);
        @(negedge clk);
        arst_n = 1'b1;

        for (i = 0; i < tests.size(); i++) begin
            run_frame(names[i], tests[i].op, tests[i].addr, tests[i].dhi, tests[i].dlo,
                      tests[i].n_reply, g0, g1, n_got);
            if (n_got >= 1) begin
                compare_byte(names[i], tests[i].rep0, g0);
            end
            if (n_got >= 2) begin
                compare_byte({names[i], " low byte"}, tests[i].rep1, g1);
            end
        end

        // write a random word, then read back any address written so far
        for (p = 0; p < N_PAIRS; p++) begin
            addr = 8'($random(seed));
            data = 16'($random(seed));
            shadow[addr] = data;
            written.push_back(addr);
            run_frame($sformatf("rnd_wr_%0d", p), OP_WRITE, addr, data[15:8], data[7:0],
                      1, g0, g1, n_got);
            if (n_got == 1) begin
                compare_byte($sformatf("rnd_wr_%0d", p), `SDU_ACK_BYTE, g0);
            end
            idx = $unsigned($random(seed)) % written.size();
            addr = written[idx];
            run_frame($sformatf("rnd_rd_%0d", p), OP_READ, addr, 8'h00, 8'h00,
                      2, g0, g1, n_got);
            if (n_got == 2) begin
                compare_word($sformatf("rnd_rd_%0d", p), shadow[addr], {g0, g1});
            end
        end

        $display("checks: %0d, mismatches: %0d, other errors: %0d",
                 n_checks, n_mismatch, n_other);
        if (n_mismatch == 0 && n_other == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

/* tb/sdu_checker.sv */
module sdu_checker (
    input logic clk,
    input logic arst_n,
    input logic rx_valid,
    input logic tx_start,
    input logic tx_busy,
    input logic txd,
    input logic mem_we,
    input logic busy
);

    // transmitter takes a new byte only when idle
    start_when_idle: assert property (@(posedge clk) disable iff (!arst_n)
        tx_start |-> !tx_busy)
        else $error("tx_start pulsed while the transmitter was busy");

    // one strobe per received byte
    single_rx_strobe: assert property (@(posedge clk) disable iff (!arst_n)
        rx_valid |=> !rx_valid)
        else $error("rx_valid high for two cycles in a row");

    // idle line is high
    idle_line_high: assert property (@(posedge clk) disable iff (!arst_n)
        !tx_busy |-> txd)
        else $error("txd low while the transmitter was idle");

    write_while_busy: assert property (@(posedge clk) disable iff (!arst_n)
        mem_we |-> busy)
        else $error("memory write outside a command");

endmodule

bind sdu_top sdu_checker u_checker (
    .clk      (clk),
    .arst_n   (arst_n),
    .rx_valid (rx_valid),
    .tx_start (tx_start),
    .tx_busy  (tx_busy),
    .txd      (txd),
    .mem_we   (mem_we),
    .busy     (busy)
);

/* hw/sdu_top.sv */
`include "sdu_settings.svh"

module sdu_top (
    input  logic       clk,
    input  logic       arst_n,
    input  logic       rxd,
    output logic       txd,
    output logic [7:0] last_rx,
    output logic       busy
);

    logic [7:0]             rx_data;
    logic                   rx_valid;
    logic                   mem_we;
    logic [`SDU_MEM_AW-1:0] mem_addr;
    logic [`SDU_MEM_DW-1:0] mem_wdata;
    logic [`SDU_MEM_DW-1:0] mem_rdata;
    logic [7:0]             tx_data;
    logic                   tx_start;
    logic                   tx_busy;

    uart_rx u_rx (
        .clk      (clk),
        .arst_n   (arst_n),
        .rxd      (rxd),
        .rx_data  (rx_data),
        .rx_valid (rx_valid)
    );

    debug_cmd_proc u_proc (
        .clk       (clk),
        .arst_n    (arst_n),
        .rx_data   (rx_data),
        .rx_valid  (rx_valid),
        .mem_rdata (mem_rdata),
        .mem_we    (mem_we),
        .mem_addr  (mem_addr),
        .mem_wdata (mem_wdata),
        .tx_data   (tx_data),
        .tx_start  (tx_start),
        .tx_busy   (tx_busy),
        .busy      (busy)
    );

    debug_mem u_mem (
        .clk       (clk),
        .mem_we    (mem_we),
        .mem_addr  (mem_addr),
        .mem_wdata (mem_wdata),
        .mem_rdata (mem_rdata)
    );

    uart_tx u_tx (
        .clk      (clk),
        .arst_n   (arst_n),
        .tx_data  (tx_data),
        .tx_start (tx_start),
        .txd      (txd),
        .tx_busy  (tx_busy)
    );

    // scan output, zero bytes leave the previous value in place
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            last_rx <= '0;
        end else if (rx_valid && rx_data != 8'h00) begin
            last_rx <= rx_data;
        end
    end

endmodule

/* hw/debug_cmd_proc.sv */
`include "sdu_settings.svh"

module debug_cmd_proc (
    input  logic                   clk,
    input  logic                   arst_n,
    input  logic [7:0]             rx_data,
    input  logic                   rx_valid,
    input  logic [`SDU_MEM_DW-1:0] mem_rdata,
    output logic                   mem_we,
    output logic [`SDU_MEM_AW-1:0] mem_addr,
    output logic [`SDU_MEM_DW-1:0] mem_wdata,
    output logic [7:0]             tx_data,
    output logic                   tx_start,
    input  logic                   tx_busy,
    output logic                   busy
);
    import sdu_cmd_pkg::*;

    cmd_state_e state_q;
    cmd_frame_u frame_q;
    logic [1:0] byte_cnt_q;
    logic [1:0] q_cnt_q;
    logic [7:0] q_data [2];
    logic       op_write;
    logic       op_read;

    assign op_write = (frame_q.fields.op == OP_WRITE);
    assign op_read  = (frame_q.fields.op == OP_READ);

    // memory side decodes straight from the field view
    assign mem_addr  = frame_q.fields.addr;
    assign mem_wdata = frame_q.fields.data;
    assign mem_we    = (state_q == EXEC) && op_write;

    // head of the reply queue goes out as soon as the transmitter is free
    assign tx_data  = q_data[0];
    assign tx_start = (state_q == REPLY) && (q_cnt_q != 2'd0) && !tx_busy;

    // covers the last byte still on the line after returning to COLLECT
    assign busy = (state_q != COLLECT) || tx_busy;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state_q    <= COLLECT;
            frame_q    <= '0;
            byte_cnt_q <= '0;
            q_cnt_q    <= '0;
        end else begin
            case (state_q)
                COLLECT: begin
                    // bytes outside COLLECT are simply dropped
                    if (rx_valid) begin
                        frame_q.raw[2'd3 - byte_cnt_q] <= rx_data;
                        byte_cnt_q <= byte_cnt_q + 2'd1;
                        if (byte_cnt_q == 2'd3) begin
                            state_q <= EXEC;
                        end
                    end
                end
                EXEC: begin
                    if (op_read) begin
                        state_q <= MEM_WAIT;
                    end else begin
                        // ack or error, one byte either way
                        q_cnt_q <= 2'd1;
                        state_q <= REPLY;
                    end
                end
                MEM_WAIT: begin
                    q_cnt_q <= 2'd2;
                    state_q <= REPLY;
                end
                REPLY: begin
                    if (tx_start) begin
                        q_cnt_q <= q_cnt_q - 2'd1;
                        if (q_cnt_q == 2'd1) begin
                            state_q <= COLLECT;
                        end
                    end
                end
                default: state_q <= COLLECT;
            endcase
        end
    end

    // reply bytes, slot 0 is the head
    always_ff @(posedge clk) begin
        if (state_q == EXEC && !op_read) begin
            q_data[0] <= op_write ? `SDU_ACK_BYTE : `SDU_ERR_BYTE;
        end else if (state_q == MEM_WAIT) begin
            // high byte first
            q_data[0] <= mem_rdata[`SDU_MEM_DW-1 -: 8];
            q_data[1] <= mem_rdata[7:0];
        end else if (tx_start) begin
            q_data[0] <= q_data[1];
        end
    end

endmodule

/* hw/debug_mem.sv */
`include "sdu_settings.svh"

module debug_mem (
    input  logic                   clk,
    input  logic                   mem_we,
    input  logic [`SDU_MEM_AW-1:0] mem_addr,
    input  logic [`SDU_MEM_DW-1:0] mem_wdata,
    output logic [`SDU_MEM_DW-1:0] mem_rdata
);

    localparam int DEPTH = 1 << `SDU_MEM_AW;

    logic [`SDU_MEM_DW-1:0] mem [DEPTH];

    // single port, read returns the old word on a same-cycle write
    always_ff @(posedge clk) begin
        if (mem_we) begin
            mem[mem_addr] <= mem_wdata;
        end
        mem_rdata <= mem[mem_addr];
    end

endmodule

/* hw/uart_tx.sv */
`include "sdu_settings.svh"

module uart_tx (
    input  logic       clk,
    input  logic       arst_n,
    input  logic [7:0] tx_data,
    input  logic       tx_start,
    output logic       txd,
    output logic       tx_busy
);
    import sdu_uart_pkg::*;

    localparam int CNT_W = $clog2(`SDU_CLKS_PER_BIT);
    localparam logic [CNT_W-1:0] FULL_LOAD = CNT_W'(`SDU_CLKS_PER_BIT - 1);

    uart_line_e       state_q;
    logic [CNT_W-1:0] cnt_q;
    logic [2:0]       bit_idx_q;
    logic [7:0]       shift_q;
    logic             tick;

    assign tick = (cnt_q == '0);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state_q   <= IDLE;
            cnt_q     <= '0;
            bit_idx_q <= '0;
            txd       <= 1'b1;
            tx_busy   <= 1'b0;
        end else begin
            // stays up one cycle past the end of the stop bit
            tx_busy <= tx_start | (state_q != IDLE);
            if (state_q != IDLE && !tick) begin
                cnt_q <= cnt_q - CNT_W'(1);
            end
            case (state_q)
                IDLE: begin
                    if (tx_start) begin
                        state_q <= START;
                        cnt_q   <= FULL_LOAD;
                        txd     <= 1'b0;
                    end
                end
                START: begin
                    if (tick) begin
                        state_q   <= DATA;
                        cnt_q     <= FULL_LOAD;
                        bit_idx_q <= '0;
                        txd       <= shift_q[0];
                    end
                end
                DATA: begin
                    if (tick) begin
                        cnt_q     <= FULL_LOAD;
                        bit_idx_q <= bit_idx_q + 3'd1;
                        if (bit_idx_q == 3'd7) begin
                            state_q <= STOP;
                            txd     <= 1'b1;
                        end else begin
                            txd <= shift_q[0];
                        end
                    end
                end
                STOP: begin
                    if (tick) begin
                        state_q <= IDLE;
                    end
                end
                default: state_q <= IDLE;
            endcase
        end
    end

    // next bit to send always waits in shift_q[0]
    always_ff @(posedge clk) begin
        if (state_q == IDLE && tx_start) begin
            shift_q <= tx_data;
        end else if (tick && (state_q == START || state_q == DATA)) begin
            shift_q <= {1'b0, shift_q[7:1]};
        end
    end

endmodule

/* hw/uart_rx.sv */
`include "sdu_settings.svh"

module uart_rx (
    input  logic       clk,
    input  logic       arst_n,
    input  logic       rxd,
    output logic [7:0] rx_data,
    output logic       rx_valid
);
    import sdu_uart_pkg::*;

    localparam int CNT_W = $clog2(`SDU_CLKS_PER_BIT);
    localparam logic [CNT_W-1:0] FULL_LOAD = CNT_W'(`SDU_CLKS_PER_BIT - 1);
    localparam logic [CNT_W-1:0] HALF_LOAD = CNT_W'(`SDU_CLKS_PER_BIT / 2 - 1);

    uart_line_e       state_q;
    logic             rxd_meta;
    logic             rxd_sync;
    logic             rxd_prev;
    logic [CNT_W-1:0] cnt_q;
    logic [2:0]       bit_idx_q;
    logic [7:0]       shift_q;
    logic             tick;

    // two-flop synchronizer, third stage for the edge detect
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            rxd_meta <= 1'b1;
            rxd_sync <= 1'b1;
            rxd_prev <= 1'b1;
        end else begin
            rxd_meta <= rxd;
            rxd_sync <= rxd_meta;
            rxd_prev <= rxd_sync;
        end
    end

    assign tick = (cnt_q == '0);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state_q   <= IDLE;
            cnt_q     <= '0;
            bit_idx_q <= '0;
            rx_valid  <= 1'b0;
        end else begin
            rx_valid <= 1'b0;
            if (state_q != IDLE && !tick) begin
                cnt_q <= cnt_q - CNT_W'(1);
            end
            case (state_q)
                IDLE: begin
                    // falling edge, aim at the middle of the start bit
                    if (rxd_prev && !rxd_sync) begin
                        state_q <= START;
                        cnt_q   <= HALF_LOAD;
                    end
                end
                START: begin
                    if (tick) begin
                        if (!rxd_sync) begin
                            state_q   <= DATA;
                            cnt_q     <= FULL_LOAD;
                            bit_idx_q <= '0;
                        end else begin
                            // glitch, line went back high
                            state_q <= IDLE;
                        end
                    end
                end
                DATA: begin
                    if (tick) begin
                        cnt_q     <= FULL_LOAD;
                        bit_idx_q <= bit_idx_q + 3'd1;
                        if (bit_idx_q == 3'd7) begin
                            state_q <= STOP;
                        end
                    end
                end
                STOP: begin
                    if (tick) begin
                        // low stop bit drops the byte
                        rx_valid <= rxd_sync;
                        state_q  <= IDLE;
                    end
                end
                default: state_q <= IDLE;
            endcase
        end
    end

    // lsb first
    always_ff @(posedge clk) begin
        if (state_q == DATA && tick) begin
            shift_q <= {rxd_sync, shift_q[7:1]};
        end
    end

    // shifter holds still until the next frame's data bits
    assign rx_data = shift_q;

endmodule

/* hw/sdu_cmd_pkg.sv */
`include "sdu_settings.svh"

package sdu_cmd_pkg;

    typedef enum logic [7:0] {
        OP_READ  = 8'h52,
        OP_WRITE = 8'h57
    } sdu_op_e;

    // opcode sits in the top byte so it lines up with the first byte on the wire
    typedef struct packed {
        sdu_op_e                op;
        logic [`SDU_MEM_AW-1:0] addr;
        logic [`SDU_MEM_DW-1:0] data;
    } cmd_fields_s;

    // same 32-bit frame, filled as bytes and decoded as fields
    typedef union packed {
        logic [3:0][7:0] raw;
        cmd_fields_s     fields;
    } cmd_frame_u;

    typedef enum logic [1:0] {
        COLLECT,
        EXEC,
        MEM_WAIT,
        REPLY
    } cmd_state_e;

endpackage

/* hw/sdu_uart_pkg.sv */
package sdu_uart_pkg;

    // phases of one serial character, shared by rx and tx
    typedef enum logic [1:0] {
        IDLE,
        START,
        DATA,
        STOP
    } uart_line_e;

endpackage

/* hw/sdu_settings.svh */
`ifndef SDU_SETTINGS_SVH
`define SDU_SETTINGS_SVH

// clock cycles per serial bit, kept short for simulation
`define SDU_CLKS_PER_BIT 16

// debug memory geometry
`define SDU_MEM_AW 8
`define SDU_MEM_DW 16

// reply codes
// "K" after a write
`define SDU_ACK_BYTE 8'h4B
// "?" for an opcode that is not understood
`define SDU_ERR_BYTE 8'h3F

`endif
